//--- clink_config.svh
// clink csr address map, field widths and reset defaults
`ifndef CLINK_CONFIG_SVH
`define CLINK_CONFIG_SVH

// ############################
// widths
// ############################

`define CLINK_RW   64   // register data width
`define CLINK_AW   8    // access address, bits [7:2] decoded
`define CLINK_IDW  16   // chip id
`define CLINK_NERR 7    // device error inputs

// ############################
// register byte offsets
// ############################

`define CLINK_CHIPID     8'h08
`define CLINK_RESET      8'h0C   // soft reset, bit 0
`define CLINK_TXMODE     8'h10
`define CLINK_RXMODE     8'h14
`define CLINK_ERRCTRL    8'h18   // shutdown mask + counter source
`define CLINK_ERRSTATUS  8'h1C   // sticky
`define CLINK_ERRCOUNT   8'h20   // read only
`define CLINK_SPICLK     8'h24
`define CLINK_SPITIMEOUT 8'h28
`define CLINK_CRDTINIT   8'h2C   // {resp, req}
`define CLINK_CRDTINTRVL 8'h30
`define CLINK_CRDTSTAT   8'h34   // read only, from tx credit logic

// ############################
// reset defaults
// ############################

`define CLINK_DEF_SPICLK     8'h04
`define CLINK_DEF_SPITIMEOUT 32'h0000_1000
`define CLINK_DEF_CRDTINIT   {16'd42, 16'd42}   // resp and req halves
`define CLINK_DEF_CRDTINTRVL 16'h00FF

`endif

//--- clink_pkg.sv
// clink csr types: register select, error code and word types
`default_nettype none

`include "clink_config.svh"

package clink_pkg;

   // ############################
   // word types
   // ############################

   typedef logic [`CLINK_RW-1:0]   csr_word_t;    // full register word
   typedef logic [31:0]            mode_word_t;   // tx/rx mode
   typedef logic [`CLINK_IDW-1:0]  chipid_t;
   typedef logic [`CLINK_NERR-1:0] err_vec_t;     // one bit per device error

   // decoded register select, one per mapped offset
   typedef enum logic [3:0] {
      SEL_NONE       = 4'd0,   // unmapped
      SEL_CHIPID     = 4'd1,
      SEL_RESET      = 4'd2,
      SEL_TXMODE     = 4'd3,
      SEL_RXMODE     = 4'd4,
      SEL_ERRCTRL    = 4'd5,
      SEL_ERRSTATUS  = 4'd6,
      SEL_ERRCOUNT   = 4'd7,
      SEL_SPICLK     = 4'd8,
      SEL_SPITIMEOUT = 4'd9,
      SEL_CRDTINIT   = 4'd10,
      SEL_CRDTINTRVL = 4'd11,
      SEL_CRDTSTAT   = 4'd12
   } reg_sel_e;

   // error code, highest pending status bit plus one
   typedef enum logic [2:0] {
      ERR_NONE      = 3'd0,   // normal
      ERR_OVERVOLT  = 3'd1,   // lower supply
      ERR_UNDERVOLT = 3'd2,   // raise supply
      ERR_TEMP      = 3'd3,   // slow down
      ERR_CLKGLITCH = 3'd4,   // needs reset
      ERR_WATCHDOG  = 3'd5,   // needs reset
      ERR_LINKFAULT = 3'd6,   // recalibrate
      ERR_FATAL     = 3'd7    // shutdown
   } err_code_e;

endpackage

`default_nettype wire

//--- clink_reg_decode.sv
// stage 1 access register and address to register select decode
`timescale 1ns/10ps
`default_nettype none

`include "clink_config.svh"

module clink_reg_decode
  (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       reg_write,   // one cycle strobe
   input  wire                       reg_read,    // never with reg_write
   input  wire [`CLINK_AW-1:0]       reg_addr,    // byte address
   input  wire clink_pkg::csr_word_t reg_wrdata,
   output logic                      dec_write,
   output logic                      dec_read,
   output clink_pkg::reg_sel_e       dec_sel,
   output clink_pkg::csr_word_t      dec_wrdata
  );

   clink_pkg::reg_sel_e sel_nxt;   // decode of the current address

   // word address compare, byte lanes ignored
   always_comb
   begin
      case (reg_addr[`CLINK_AW-1:2])
         6'(`CLINK_CHIPID >> 2)     : sel_nxt = clink_pkg::SEL_CHIPID;
         6'(`CLINK_RESET >> 2)      : sel_nxt = clink_pkg::SEL_RESET;
         6'(`CLINK_TXMODE >> 2)     : sel_nxt = clink_pkg::SEL_TXMODE;
         6'(`CLINK_RXMODE >> 2)     : sel_nxt = clink_pkg::SEL_RXMODE;
         6'(`CLINK_ERRCTRL >> 2)    : sel_nxt = clink_pkg::SEL_ERRCTRL;
         6'(`CLINK_ERRSTATUS >> 2)  : sel_nxt = clink_pkg::SEL_ERRSTATUS;
         6'(`CLINK_ERRCOUNT >> 2)   : sel_nxt = clink_pkg::SEL_ERRCOUNT;
         6'(`CLINK_SPICLK >> 2)     : sel_nxt = clink_pkg::SEL_SPICLK;
         6'(`CLINK_SPITIMEOUT >> 2) : sel_nxt = clink_pkg::SEL_SPITIMEOUT;
         6'(`CLINK_CRDTINIT >> 2)   : sel_nxt = clink_pkg::SEL_CRDTINIT;
         6'(`CLINK_CRDTINTRVL >> 2) : sel_nxt = clink_pkg::SEL_CRDTINTRVL;
         6'(`CLINK_CRDTSTAT >> 2)   : sel_nxt = clink_pkg::SEL_CRDTSTAT;
         default                    : sel_nxt = clink_pkg::SEL_NONE;   // hole in map
      endcase
   end

   // ############################
   // access pipeline register
   // ############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         dec_write <= 1'b0;
         dec_read  <= 1'b0;
         dec_sel   <= clink_pkg::SEL_NONE;
      end
      else
      begin
         dec_write <= reg_write;
         dec_read  <= reg_read;
         dec_sel   <= sel_nxt;   // follows address every cycle
      end
   end

   // write data, qualified downstream by dec_write
   always_ff @(posedge clk)
   begin
      dec_wrdata <= reg_wrdata;
   end

endmodule

`default_nettype wire

//--- clink_link_regs.sv
// stage 2 link mode, chip id, spi, credit and soft reset registers, link-active flag
`timescale 1ns/10ps
`default_nettype none

`include "clink_config.svh"

module clink_link_regs
  (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       dec_write,
   input  wire clink_pkg::reg_sel_e  dec_sel,
   input  wire clink_pkg::csr_word_t dec_wrdata,
   input  wire                       device_ready,   // device finished init
   // tx mode
   output logic                      csr_txen,
   output logic                      csr_txddrmode,
   output logic [1:0]                csr_txarbmode,
   output logic                      csr_txcrdt_en,
   output logic [3:0]                csr_txprotocol,
   output logic [3:0]                csr_txeccmode,
   output logic [7:0]                csr_txiowidth,
   // rx mode
   output logic                      csr_rxen,
   output logic                      csr_rxddrmode,
   output logic [1:0]                csr_rxarbmode,
   output logic [3:0]                csr_rxprotocol,
   output logic [3:0]                csr_rxeccmode,
   output logic [7:0]                csr_rxiowidth,
   // misc
   output clink_pkg::chipid_t        device_chipid,
   output logic [7:0]                csr_spidiv,
   output logic [31:0]               csr_spitimeout,
   output logic [15:0]               csr_rxcrdt_req_init,
   output logic [15:0]               csr_rxcrdt_resp_init,
   output logic [15:0]               csr_txcrdt_intrvl,
   output logic                      soft_reset,     // core held while set
   // readback
   output clink_pkg::mode_word_t     txmode_q,
   output clink_pkg::mode_word_t     rxmode_q
  );

   logic [31:0] crdtinit_q;   // {resp, req}
   logic        link_active;  // sticky after device_ready

   // ############################
   // register writes
   // ############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         txmode_q            <= '0;   // link must be configured first
         rxmode_q            <= '0;
         device_chipid       <= '0;
         csr_spidiv          <= `CLINK_DEF_SPICLK;
         csr_spitimeout      <= `CLINK_DEF_SPITIMEOUT;
         crdtinit_q          <= `CLINK_DEF_CRDTINIT;
         csr_txcrdt_intrvl   <= `CLINK_DEF_CRDTINTRVL;
         soft_reset          <= 1'b1;  // core starts in reset
      end
      else if (dec_write)
      begin
         case (dec_sel)
            clink_pkg::SEL_TXMODE     : txmode_q <= dec_wrdata[31:0];
            clink_pkg::SEL_RXMODE     : rxmode_q <= dec_wrdata[31:0];
            clink_pkg::SEL_CHIPID     : device_chipid <= dec_wrdata[`CLINK_IDW-1:0];
            clink_pkg::SEL_SPICLK     : csr_spidiv <= dec_wrdata[7:0];
            clink_pkg::SEL_SPITIMEOUT : csr_spitimeout <= dec_wrdata[31:0];
            clink_pkg::SEL_CRDTINIT   : crdtinit_q <= dec_wrdata[31:0];
            clink_pkg::SEL_CRDTINTRVL : csr_txcrdt_intrvl <= dec_wrdata[15:0];
            clink_pkg::SEL_RESET      : soft_reset <= dec_wrdata[0];
            default                   : ;   // error block or unmapped
         endcase
      end
   end

   // link comes up once, stays up until nreset
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         link_active <= 1'b0;
      else if (device_ready)
         link_active <= 1'b1;
   end

   // ############################
   // mode field breakout
   // ############################

   assign csr_txen       = txmode_q[0] & link_active;   // gated enable
   assign csr_txddrmode  = txmode_q[1];      // 1=ddr
   assign csr_txarbmode  = txmode_q[3:2];
   assign csr_txcrdt_en  = txmode_q[4];      // send credit updates
   assign csr_txprotocol = txmode_q[11:8];
   assign csr_txeccmode  = txmode_q[15:12];
   assign csr_txiowidth  = txmode_q[23:16];  // bytes, 0=off

   assign csr_rxen       = rxmode_q[0] & link_active;
   assign csr_rxddrmode  = rxmode_q[1];
   assign csr_rxarbmode  = rxmode_q[3:2];
   assign csr_rxprotocol = rxmode_q[11:8];
   assign csr_rxeccmode  = rxmode_q[15:12];
   assign csr_rxiowidth  = rxmode_q[23:16];

   // credit init halves
   assign csr_rxcrdt_req_init  = crdtinit_q[15:0];
   assign csr_rxcrdt_resp_init = crdtinit_q[31:16];

endmodule

`default_nettype wire

//--- clink_err_regs.sv
// stage 2 error control, sticky status, priority code, error counter and core hold
`timescale 1ns/10ps
`default_nettype none

`include "clink_config.svh"

module clink_err_regs
  (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       dec_write,
   input  wire clink_pkg::reg_sel_e  dec_sel,
   input  wire clink_pkg::csr_word_t dec_wrdata,
   input  wire clink_pkg::err_vec_t  device_error,  // level, sampled each cycle
   input  wire                       soft_reset,
   output clink_pkg::err_code_e      error_code,
   output logic                      core_hold,
   output logic [11:0]               errctrl_q,
   output logic [15:0]               errstatus_q,
   output logic [15:0]               errcount_q
  );

   logic [15:0]            error_in;   // status input vector
   logic [3:0]             cnt_src;    // counted status input
   logic [`CLINK_NERR-1:0] shutdown;   // mask of hold-worthy codes
   logic [`CLINK_NERR-1:0] err_hit;    // one-hot of current code

   assign error_in = 16'(device_error);   // upper bits reserved
   assign shutdown = errctrl_q[`CLINK_NERR-1:0];
   assign cnt_src  = errctrl_q[11:8];

   // ############################
   // control and sticky status
   // ############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         errctrl_q   <= '0;
         errstatus_q <= '0;
      end
      else
      begin
         if (dec_write && (dec_sel == clink_pkg::SEL_ERRCTRL))
            errctrl_q <= dec_wrdata[11:0];
         if (dec_write && (dec_sel == clink_pkg::SEL_ERRSTATUS))
            errstatus_q <= dec_wrdata[15:0];   // software clear/set
         else
            errstatus_q <= errstatus_q | error_in;   // accumulate
      end
   end

   // free running count of the selected input, not writable
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         errcount_q <= '0;
      else
         errcount_q <= errcount_q + 16'(error_in[cnt_src]);
   end

   // ############################
   // priority code and hold
   // ############################

   // highest pending bit wins
   always_comb
   begin
      error_code = clink_pkg::ERR_NONE;
      for (int i = 0; i < `CLINK_NERR; i++)
      begin
         if (errstatus_q[i])
            error_code = clink_pkg::err_code_e'(i + 1);
      end
   end

   // decode back to one-hot for the mask
   always_comb
   begin
      for (int i = 0; i < `CLINK_NERR; i++)
      begin
         err_hit[i] = (error_code == clink_pkg::err_code_e'(i + 1));
      end
   end

   assign core_hold = soft_reset | (|(shutdown & err_hit));   // sw or shutdown

endmodule

`default_nettype wire

//--- clink_read_mux.sv
// stage 3 registered read data select and read-valid pulse
`timescale 1ns/10ps
`default_nettype none

module clink_read_mux
  (
   input  wire                        clk,
   input  wire                        nreset,
   input  wire                        dec_read,
   input  wire clink_pkg::reg_sel_e   dec_sel,
   input  wire clink_pkg::mode_word_t txmode_q,
   input  wire clink_pkg::mode_word_t rxmode_q,
   input  wire clink_pkg::chipid_t    device_chipid,
   input  wire [7:0]                  csr_spidiv,
   input  wire [31:0]                 csr_spitimeout,
   input  wire [15:0]                 csr_rxcrdt_req_init,
   input  wire [15:0]                 csr_rxcrdt_resp_init,
   input  wire [15:0]                 csr_txcrdt_intrvl,
   input  wire                        soft_reset,
   input  wire [11:0]                 errctrl_q,
   input  wire [15:0]                 errstatus_q,
   input  wire [15:0]                 errcount_q,
   input  wire [31:0]                 csr_txcrdt_status,   // live credit state
   output logic                       rd_valid,
   output clink_pkg::csr_word_t       rd_data
  );

   clink_pkg::csr_word_t rd_word;   // zero extended selection

   always_comb
   begin
      case (dec_sel)
         clink_pkg::SEL_CHIPID     : rd_word = clink_pkg::csr_word_t'(device_chipid);
         clink_pkg::SEL_RESET      : rd_word = clink_pkg::csr_word_t'(soft_reset);
         clink_pkg::SEL_TXMODE     : rd_word = clink_pkg::csr_word_t'(txmode_q);
         clink_pkg::SEL_RXMODE     : rd_word = clink_pkg::csr_word_t'(rxmode_q);
         clink_pkg::SEL_ERRCTRL    : rd_word = clink_pkg::csr_word_t'(errctrl_q);
         clink_pkg::SEL_ERRSTATUS  : rd_word = clink_pkg::csr_word_t'(errstatus_q);
         clink_pkg::SEL_ERRCOUNT   : rd_word = clink_pkg::csr_word_t'(errcount_q);
         clink_pkg::SEL_SPICLK     : rd_word = clink_pkg::csr_word_t'(csr_spidiv);
         clink_pkg::SEL_SPITIMEOUT : rd_word = clink_pkg::csr_word_t'(csr_spitimeout);
         clink_pkg::SEL_CRDTINIT   :
            rd_word = clink_pkg::csr_word_t'({csr_rxcrdt_resp_init, csr_rxcrdt_req_init});
         clink_pkg::SEL_CRDTINTRVL : rd_word = clink_pkg::csr_word_t'(csr_txcrdt_intrvl);
         clink_pkg::SEL_CRDTSTAT   : rd_word = clink_pkg::csr_word_t'(csr_txcrdt_status);
         default                   : rd_word = '0;   // unmapped reads zero
      endcase
   end

   // one cycle pulse per read
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rd_valid <= 1'b0;
      else
         rd_valid <= dec_read;
   end

   // captured before this edge's write commit lands
   always_ff @(posedge clk)
   begin
      if (dec_read)
         rd_data <= rd_word;
   end

endmodule

`default_nettype wire

//--- clink_regs_top.sv
// clink csr block top level, decode, register and read stages
`timescale 1ns/10ps
`default_nettype none

`include "clink_config.svh"

module clink_regs_top
  (
   input  wire                        clk,
   input  wire                        nreset,
   // register access
   input  wire                        reg_write,
   input  wire                        reg_read,
   input  wire [`CLINK_AW-1:0]        reg_addr,
   input  wire clink_pkg::csr_word_t  reg_wrdata,
   output wire                        rd_valid,
   output wire clink_pkg::csr_word_t  rd_data,
   // device side
   input  wire                        device_ready,
   input  wire clink_pkg::err_vec_t   device_error,
   input  wire [31:0]                 csr_txcrdt_status,
   output wire clink_pkg::chipid_t    device_chipid,
   output wire clink_pkg::err_code_e  error_code,
   output wire                        core_hold,
   output wire                        soft_reset,
   // tx link
   output wire                        csr_txen,
   output wire                        csr_txddrmode,
   output wire [1:0]                  csr_txarbmode,
   output wire                        csr_txcrdt_en,
   output wire [3:0]                  csr_txprotocol,
   output wire [3:0]                  csr_txeccmode,
   output wire [7:0]                  csr_txiowidth,
   // rx link
   output wire                        csr_rxen,
   output wire                        csr_rxddrmode,
   output wire [1:0]                  csr_rxarbmode,
   output wire [3:0]                  csr_rxprotocol,
   output wire [3:0]                  csr_rxeccmode,
   output wire [7:0]                  csr_rxiowidth,
   // spi and credits
   output wire [7:0]                  csr_spidiv,
   output wire [31:0]                 csr_spitimeout,
   output wire [15:0]                 csr_rxcrdt_req_init,
   output wire [15:0]                 csr_rxcrdt_resp_init,
   output wire [15:0]                 csr_txcrdt_intrvl
  );

   // ############################
   // stage wiring
   // ############################

   wire                        dec_write;
   wire                        dec_read;
   wire clink_pkg::reg_sel_e   dec_sel;
   wire clink_pkg::csr_word_t  dec_wrdata;
   wire clink_pkg::mode_word_t txmode_q;    // readback only
   wire clink_pkg::mode_word_t rxmode_q;
   wire [11:0]                 errctrl_q;
   wire [15:0]                 errstatus_q;
   wire [15:0]                 errcount_q;

   clink_reg_decode u_decode (.*);   // stage 1

   clink_link_regs u_link (.*);      // stage 2, link side

   clink_err_regs u_err (.*);        // stage 2, errors

   clink_read_mux u_rdmux (.*);      // stage 3

endmodule

`default_nettype wire

//--- clink_regs_chk.sv
// bound assertions on the clink csr top: read valid timing, tx enable gating, strobes
`timescale 1ns/10ps
`default_nettype none

module clink_regs_chk
  (
   input wire clk,
   input wire nreset,
   input wire reg_write,
   input wire reg_read,
   input wire rd_valid,
   input wire device_ready,
   input wire csr_txen
  );

   logic ready_seen;   // device_ready observed since reset

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         ready_seen <= 1'b0;
      else if (device_ready)
         ready_seen <= 1'b1;
   end

   // read data two edges after the access is sampled
   read_valid_follows : assert property (@(posedge clk) disable iff (!nreset)
      reg_read |-> ##2 rd_valid)
      else $error("rd_valid missing after a sampled read");

   tx_gated_by_ready : assert property (@(posedge clk) disable iff (!nreset)
      !ready_seen |-> !csr_txen)
      else $error("csr_txen high before device_ready was seen");

   // never both strobes at once
   strobes_exclusive : assert property (@(posedge clk) disable iff (!nreset)
      !(reg_write && reg_read))
      else $error("reg_write and reg_read asserted together");

endmodule

bind clink_regs_top clink_regs_chk u_chk (.*);

`default_nettype wire

//--- clink_regs_tb.sv
// clink csr testbench: case file driver, read monitor, compare tasks and watchdog
`timescale 1ns/10ps
`default_nettype none

`include "clink_config.svh"

module clink_regs_tb;

   logic                       clk;
   logic                       nreset;
   logic                       reg_write;
   logic                       reg_read;
   logic [`CLINK_AW-1:0]       reg_addr;
   clink_pkg::csr_word_t       reg_wrdata;
   logic                       device_ready;
   clink_pkg::err_vec_t        device_error;
   logic [31:0]                csr_txcrdt_status;
   wire                        rd_valid;
   wire clink_pkg::csr_word_t  rd_data;
   wire clink_pkg::chipid_t    device_chipid;
   wire clink_pkg::err_code_e  error_code;
   wire                        core_hold, soft_reset;
   wire                        csr_txen, csr_txddrmode, csr_txcrdt_en, csr_rxen, csr_rxddrmode;
   wire [1:0]                  csr_txarbmode, csr_rxarbmode;
   wire [3:0]                  csr_txprotocol, csr_txeccmode, csr_rxprotocol, csr_rxeccmode;
   wire [7:0]                  csr_txiowidth, csr_rxiowidth, csr_spidiv;
   wire [31:0]                 csr_spitimeout;
   wire [15:0]                 csr_rxcrdt_req_init, csr_rxcrdt_resp_init, csr_txcrdt_intrvl;

   // case table, one entry per file line
   string                      c_name[$];
   string                      c_op[$];
   logic [`CLINK_AW-1:0]       c_addr[$];
   clink_pkg::csr_word_t       c_data[$];
   clink_pkg::csr_word_t       c_exp[$];
   logic                       c_rdy[$];
   clink_pkg::err_vec_t        c_err[$];
   // reads in flight, oldest first
   string                      rd_name[$];
   logic [`CLINK_AW-1:0]       rd_addr[$];
   clink_pkg::csr_word_t       rd_exp[$];
   int                         rd_cyc[$];
   int                         cycle_cnt = 0;    // posedges since start
   logic                       loaded = 1'b0;    // case table ready
   clink_pkg::csr_word_t       pin_word;         // output pins in register layout
   clink_pkg::csr_word_t       pin_mask;         // bits backed by a pin

   clink_regs_top dut (.*);

   task automatic fail_stop(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first failure");
   endtask

   // ############################
   // compare tasks
   // ############################

   task automatic check_word(input string name, input clink_pkg::csr_word_t exp,
                             input clink_pkg::csr_word_t act);
      if (act !== exp)
         fail_stop($sformatf("error %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_code(input string name, input clink_pkg::err_code_e exp,
                             input clink_pkg::err_code_e act);
      if (act !== exp)
         fail_stop($sformatf("error %s expected %s actual %s", name, exp.name(), act.name()));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_stop($sformatf("error %s expected %b actual %b", name, exp, act));
   endtask

   // register layout rebuilt from the output pins
   function automatic void pin_view(input logic [`CLINK_AW-1:0] addr,
                                    output clink_pkg::csr_word_t word,
                                    output clink_pkg::csr_word_t mask);
      word = '0;
      mask = '0;
      case (addr)
         `CLINK_CHIPID :
         begin
            word = clink_pkg::csr_word_t'(device_chipid);
            mask = 64'h0000_FFFF;
         end
         `CLINK_RESET :
         begin
            word = clink_pkg::csr_word_t'(soft_reset);
            mask = 64'h1;
         end
         `CLINK_TXMODE :
         begin
            word = {40'h0, csr_txiowidth, csr_txeccmode, csr_txprotocol, 3'b000,
                    csr_txcrdt_en, csr_txarbmode, csr_txddrmode, 1'b0};
            mask = 64'h00FF_FF1E;   // enable is gated, checked apart
         end
         `CLINK_RXMODE :
         begin
            word = {40'h0, csr_rxiowidth, csr_rxeccmode, csr_rxprotocol, 4'h0,
                    csr_rxarbmode, csr_rxddrmode, 1'b0};
            mask = 64'h00FF_FF0E;   // no rx credit enable pin
         end
         `CLINK_SPICLK :
         begin
            word = clink_pkg::csr_word_t'(csr_spidiv);
            mask = 64'hFF;
         end
         `CLINK_SPITIMEOUT :
         begin
            word = clink_pkg::csr_word_t'(csr_spitimeout);
            mask = 64'hFFFF_FFFF;
         end
         `CLINK_CRDTINIT :
         begin
            word = clink_pkg::csr_word_t'({csr_rxcrdt_resp_init, csr_rxcrdt_req_init});
            mask = 64'hFFFF_FFFF;
         end
         `CLINK_CRDTINTRVL :
         begin
            word = clink_pkg::csr_word_t'(csr_txcrdt_intrvl);
            mask = 64'hFFFF;
         end
         default : ;   // no pins behind this register
      endcase
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   // read response due two edges after issue, checked on the falling edge
   // pins still hold the read value, the capture edge commits no write
   always @(negedge clk)
   begin
      if (rd_cyc.size() != 0 && rd_cyc[0] + 2 == cycle_cnt)
      begin
         check_bit({rd_name[0], "_valid"}, 1'b1, rd_valid);
         check_word(rd_name[0], rd_exp[0], rd_data);
         pin_view(rd_addr[0], pin_word, pin_mask);
         if (pin_mask != '0)
            check_word({rd_name[0], "_pins"}, rd_exp[0] & pin_mask, pin_word);
         void'(rd_name.pop_front());
         void'(rd_addr.pop_front());
         void'(rd_exp.pop_front());
         void'(rd_cyc.pop_front());
      end
      else if (rd_valid === 1'b1)
         fail_stop("rd_valid pulsed with no read outstanding");
   end

   // ############################
   // case driver
   // ############################

   initial
   begin : driver
      int                   fd;
      int                   n;
      int                   rdy;
      string                line;
      string                nm;
      string                op;
      logic [63:0]          a;
      logic [63:0]          d;
      logic [63:0]          e;
      logic [63:0]          ev;
      nreset            = 1'b0;
      reg_write         = 1'b0;
      reg_read          = 1'b0;
      reg_addr          = '0;
      reg_wrdata        = '0;
      device_ready      = 1'b0;
      device_error      = '0;
      csr_txcrdt_status = '0;
      fd = $fopen("clink_regs_cases.txt", "r");
      if (fd == 0)
         fail_stop("cannot open clink_regs_cases.txt");
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 1 && line.getc(0) != "#")   // skip comments and blank lines
         begin
            if ($sscanf(line, "%s %s %h %h %h %d %h", nm, op, a, d, e, rdy, ev) != 7)
               fail_stop({"malformed case line: ", line});
            c_name.push_back(nm);
            c_op.push_back(op);
            c_addr.push_back(a[`CLINK_AW-1:0]);
            c_data.push_back(d);
            c_exp.push_back(e);
            c_rdy.push_back(rdy[0]);
            c_err.push_back(ev[`CLINK_NERR-1:0]);
         end
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (2) @(negedge clk);
      nreset = 1'b1;
      for (int i = 0; i < c_op.size(); i++)
      begin
         @(negedge clk);
         reg_write    = 1'b0;
         reg_read     = 1'b0;
         device_ready = c_rdy[i];   // levels hold for the whole line
         device_error = c_err[i];
         case (c_op[i])
            "wr" :
            begin
               reg_write  = 1'b1;
               reg_addr   = c_addr[i];
               reg_wrdata = c_data[i];
            end
            "rd" :
            begin
               reg_read = 1'b1;
               reg_addr = c_addr[i];
               rd_name.push_back(c_name[i]);
               rd_addr.push_back(c_addr[i]);
               rd_exp.push_back(c_exp[i]);
               rd_cyc.push_back(cycle_cnt);
            end
            "idle" : repeat (int'(c_data[i]) - 1) @(negedge clk);   // data is cycles
            "crdt" : csr_txcrdt_status = c_data[i][31:0];
            "code" : check_code(c_name[i], clink_pkg::err_code_e'(c_exp[i][2:0]), error_code);
            "hold" : check_bit(c_name[i], c_exp[i][0], core_hold);
            "txen" : check_bit(c_name[i], c_exp[i][0], csr_txen);
            "rxen" : check_bit(c_name[i], c_exp[i][0], csr_rxen);
            "rdv"  : check_bit(c_name[i], c_exp[i][0], rd_valid);
            default : fail_stop({"unknown operation in case file: ", c_op[i]});
         endcase
      end
      @(negedge clk);
      reg_write    = 1'b0;
      reg_read     = 1'b0;
      device_ready = 1'b0;
      device_error = '0;
      repeat (3) @(negedge clk);   // drain, reads answer two edges after issue
      if (rd_cyc.size() == 0)
      begin
         $display("STATUS: PASS");
         $finish;
      end
      else
         fail_stop("read responses still missing at end of run");
   end

   // 20 cycles per case line plus 50
   initial
   begin : watchdog
      wait (loaded);
      #((c_op.size() * 20 + 50) * 10);
      fail_stop("timeout, case sequence did not complete");
   end

endmodule

`default_nettype wire

//--- clink_regs_cases.txt
# name op addr data expected ready error, hex except ready (0/1), one line per cycle
# ops wr rd idle crdt code hold txen rxen rdv, idle data counts cycles
crdt_set    crdt 00 a5a5c33c         0        0 00
rst_rdv     rdv  00 0                0        0 00
rst_hold    hold 00 0                1        0 00
rst_spiclk  rd   24 0                4        0 00
rst_spito   rd   28 0                1000     0 00
rst_crinit  rd   2c 0                2a002a   0 00
rst_crint   rd   30 0                ff       0 00
rst_soft    rd   0c 0                1        0 00
rst_txmode  rd   10 0                0        0 00
rst_code    code 00 0                0        0 00
wr_chipid   wr   08 ffffffffffff1234 0        0 00
rd_chipid   rd   08 0                1234     0 00
wr_spiclk   wr   24 1a7              0        0 00
wr_spito    wr   28 ffffffff00c0ffee 0        0 00
wr_crinit   wr   2c 100020           0        0 00
wr_crint    wr   30 123456789        0        0 00
wr_txmode   wr   10 ffffffff00ab3f1f 0        0 00
wr_rxmode   wr   14 cd5e0d           0        0 00
wr_errcnt   wr   20 ffff             0        0 00
wr_unmap    wr   3c ffffffff         0        0 00
rd_spiclk   rd   24 0                a7       0 00
rd_spito    rd   28 0                c0ffee   0 00
rd_crinit   rd   2c 0                100020   0 00
rd_crint    rd   30 0                6789     0 00
rd_txmode   rd   10 0                ab3f1f   0 00
rd_rxmode   rd   14 0                cd5e0d   0 00
rd_errcnt   rd   20 0                0        0 00
rd_unmap    rd   3c 0                0        0 00
rd_crstat   rd   34 0                a5a5c33c 0 00
txen_off    txen 00 0                0        0 00
rxen_off    rxen 00 0                0        0 00
rdy_pulse   idle 00 1                0        1 00
txen_on     txen 00 0                1        0 00
idle_link   idle 00 3                0        0 00
rxen_on     rxen 00 0                1        0 00
err1        idle 00 1                0        0 02
err4        idle 00 1                0        0 10
code_wd     code 00 0                5        0 00
rd_errst    rd   1c 0                12       0 00
wr_errclr   wr   1c 0                0        0 00
wr_ctl_cnt  wr   18 fffff200         0        0 00
idle_clr    idle 00 1                0        0 00
code_clr    code 00 0                0        0 00
rd_errctl   rd   18 0                200      0 00
cnt_err     idle 00 6                0        0 04
rd_count    rd   20 0                6        0 00
wr_errclr2  wr   1c 0                0        0 00
wr_ctl_hold wr   18 40               0        0 00
wr_reset    wr   0c 0                0        0 00
idle_rel    idle 00 1                0        0 00
hold_off    hold 00 0                0        0 00
rd_soft     rd   0c 0                0        0 00
err6        idle 00 1                0        0 40
hold_on     hold 00 0                1        0 00
code_fatal  code 00 0                7        0 00

//--- project.f
+incdir+.
clink_pkg.sv
clink_reg_decode.sv
clink_link_regs.sv
clink_err_regs.sv
clink_read_mux.sv
clink_regs_top.sv
clink_regs_chk.sv
clink_regs_tb.sv

//--- Bender.yml
package:
  name: clink

export_include_dirs:
  - .

sources:
  - clink_pkg.sv
  - clink_reg_decode.sv
  - clink_link_regs.sv
  - clink_err_regs.sv
  - clink_read_mux.sv
  - clink_regs_top.sv
  - target: test
    files:
      - clink_regs_chk.sv
      - clink_regs_tb.sv
